//--- design/agnus_dma.sv
// agnus_dma
// chip bus DMA slot allocation: beam timer, DMACON, the dma peers
// and the arbiter that hands each slot to one peer or the cpu

module agnus_dma (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic                                   ntsc,
  input  logic                                   turbo,
  input  logic                                   bls,         // cpu waiting, slow blitter
  input  logic                                   aen,
  input  logic                                   rd,
  input  logic                                   hwr,
  input  logic                                   lwr,
  input  agnus_pkg::reg_addr_t                   address_in,
  input  logic [15:0]                            data_in,
  input  logic                                   disk_dmal,
  input  logic                                   disk_write,
  input  logic [agnus_pkg::AUDIO_CHANNELS-1:0]   audio_dmal,
  output logic [15:0]                            data_out,
  output agnus_pkg::chip_addr_t                  address_out,
  output agnus_pkg::reg_addr_t                   reg_address_out,
  output logic                                   dbr,
  output logic                                   dbwe,
  output logic                                   cpu_custom,
  output logic                                   int3,
  output logic                                   sol
);
  import agnus_pkg::*;

  logic [8:0]  hpos;
  logic        ref_dma, dsk_dma, aud_dma;
  logic        spr_req, cop_req, blt_req;
  logic        spr_ack, cop_ack, blt_ack;
  logic        spren, copen, blten, bltpri, blit_busy;
  logic [15:0] dmaconr;
  cpu_reg_t    cpu, reg_wr;
  dma_bus_t    dsk_bus, aud_bus, spr_bus, cop_bus, blt_bus;

  // cpu side, address only valid during a bus access
  assign cpu = '{addr: (aen && (rd || hwr || lwr)) ? address_in : REG_NONE,
                 data: data_in,
                 wr:   aen && (hwr || lwr)};

  assign data_out = dmaconr;

  beam_slot_timer u_beam (.clk, .reset, .ntsc, .hpos, .sol, .refresh(ref_dma));

  dma_control u_dmacon (
    .clk, .reset, .reg_wr, .blit_busy, .spren, .copen, .blten, .bltpri, .dmaconr
  );

  fixed_slot_dma #(
    .NUM_CH(1), .NUM_SLOTS(DISK_SLOTS), .SLOT_BASE(DISK_SLOT_BASE),
    .PT_REG_BASE(REG_DSKPTH), .PT_STRIDE(0),
    .DAT_REG_BASE(REG_DSKDAT), .DAT_STRIDE(0)
  ) u_disk (
    .clk, .reset, .hpos, .dmal(disk_dmal), .dir_write(disk_write), .reg_wr,
    .dma(dsk_dma), .bus(dsk_bus)
  );

  fixed_slot_dma #(
    .NUM_CH(AUDIO_CHANNELS), .NUM_SLOTS(AUDIO_CHANNELS), .SLOT_BASE(AUDIO_SLOT_BASE),
    .PT_REG_BASE(REG_AUD0LCH), .PT_STRIDE(AUD_STRIDE),
    .DAT_REG_BASE(REG_AUD0DAT), .DAT_STRIDE(AUD_STRIDE)
  ) u_audio (
    .clk, .reset, .hpos, .dmal(audio_dmal), .dir_write(1'b0), .reg_wr,
    .dma(aud_dma), .bus(aud_bus)
  );

  pointer_dma #(
    .SLOT_PHASE(SPR_SLOT_PHASE), .WIN_START(SPR_WIN_START), .WIN_END(SPR_WIN_END),
    .PT_REG(REG_SPRPTH), .DAT_REG(REG_SPRDAT), .RELOAD_AT_SOL(1'b1)
  ) u_sprite (
    .clk, .reset, .hpos, .sol, .enable(spren), .reg_wr,
    .req(spr_req), .ack(spr_ack), .bus(spr_bus)
  );

  pointer_dma #(
    .SLOT_PHASE(COP_SLOT_PHASE), .WIN_START(0), .WIN_END(HTOTAL_PAL),
    .PT_REG(REG_COP1LCH), .DAT_REG(REG_COPINS), .RELOAD_AT_SOL(1'b0)
  ) u_copper (
    .clk, .reset, .hpos, .sol, .enable(copen), .reg_wr,
    .req(cop_req), .ack(cop_ack), .bus(cop_bus)
  );

  blitter_dma u_blitter (
    .clk, .reset, .hpos, .turbo, .enable(blten), .reg_wr,
    .req(blt_req), .ack(blt_ack), .busy(blit_busy), .int3, .bus(blt_bus)
  );

  chip_bus_arbiter u_arbiter (
    .clk, .reset, .hpos, .turbo, .bls, .bltpri, .cpu,
    .dsk_dma, .aud_dma, .ref_dma, .spr_req, .cop_req, .blt_req,
    .dsk_bus, .aud_bus, .spr_bus, .cop_bus, .blt_bus,
    .spr_ack, .cop_ack, .blt_ack, .reg_wr,
    .address_out, .reg_address_out, .dbr, .dbwe, .cpu_custom
  );

endmodule

//--- design/agnus_pkg.sv
// agnus_pkg
// shared types, custom register word addresses and beam slot constants
// for the chip bus DMA slot allocator

package agnus_pkg;

  typedef logic [20:1] chip_addr_t;  // chip ram word address
  typedef logic [8:1]  reg_addr_t;   // custom register word address

  localparam reg_addr_t REG_NONE = 8'hFF;  // idle register bus

  // bus request from one dma peer
  typedef struct packed {
    chip_addr_t addr;
    reg_addr_t  reg_addr;  // data register the fetched word goes to
    logic       write;     // chip ram write cycle
  } dma_bus_t;

  // cpu register access
  typedef struct packed {
    reg_addr_t   addr;
    logic [15:0] data;
    logic        wr;
  } cpu_reg_t;

  // ----------------------------------------------------------
  // register word addresses (byte address >> 1)
  localparam reg_addr_t REG_DMACONR = 8'h01;
  localparam reg_addr_t REG_DMACON  = 8'h4B;
  localparam reg_addr_t REG_DSKPTH  = 8'h10;
  localparam reg_addr_t REG_DSKPTL  = 8'h11;
  localparam reg_addr_t REG_AUD0LCH = 8'h50;  // next channel 8 words up
  localparam reg_addr_t REG_AUD0LCL = 8'h51;
  localparam int        AUD_STRIDE  = 8;
  localparam reg_addr_t REG_SPRPTH  = 8'h90;
  localparam reg_addr_t REG_SPRPTL  = 8'h91;
  localparam reg_addr_t REG_COP1LCH = 8'h40;
  localparam reg_addr_t REG_COP1LCL = 8'h41;
  localparam reg_addr_t REG_COPJMP  = 8'h44;
  localparam reg_addr_t REG_BLTPTH  = 8'h2A;  // blitter D pointer
  localparam reg_addr_t REG_BLTPTL  = 8'h2B;
  localparam reg_addr_t REG_BLTSIZE = 8'h2C;

  // data register targets of the fetches
  localparam reg_addr_t REG_DSKDAT  = 8'h13;
  localparam reg_addr_t REG_AUD0DAT = 8'h55;
  localparam reg_addr_t REG_SPRDAT  = 8'hA2;
  localparam reg_addr_t REG_COPINS  = 8'h46;
  localparam reg_addr_t REG_BLTDDAT = 8'h00;

  // ----------------------------------------------------------
  // horizontal slot map
  localparam int HTOTAL_PAL  = 227;  // last hpos of a line
  localparam int HTOTAL_NTSC = 226;
  localparam logic [2:0][8:0] REFRESH_SLOTS = {9'd5, 9'd3, 9'd1};
  localparam int SLOT_STEP       = 2;  // fixed slots sit on odd hpos
  localparam int DISK_SLOT_BASE  = 7;
  localparam int DISK_SLOTS      = 3;
  localparam int AUDIO_SLOT_BASE = 13;
  localparam int AUDIO_CHANNELS  = 4;
  localparam int SPR_WIN_START   = 21;
  localparam int SPR_WIN_END     = 51;
  localparam int SPR_SLOT_PHASE  = 3;  // hpos[1:0] of sprite fetches
  localparam int COP_SLOT_PHASE  = 1;
  localparam logic [1:0] BLS_CNT_MAX = 2'd3;

endpackage

//--- design/beam_slot_timer.sv
// beam_slot_timer
// horizontal beam counter, one count per bus slot, with the
// start of line pulse and the refresh slot decode

module beam_slot_timer (
  input  logic       clk,
  input  logic       reset,
  input  logic       ntsc,
  output logic [8:0] hpos,
  output logic       sol,
  output logic       refresh
);
  import agnus_pkg::*;

  logic [8:0] htotal;  // last position of the current line

  assign htotal = ntsc ? 9'(HTOTAL_NTSC) : 9'(HTOTAL_PAL);

  always_ff @(posedge clk) begin
    if (reset)
      hpos <= '0;
    else if (hpos >= htotal)  // also catches a pal->ntsc switch late in the line
      hpos <= '0;
    else
      hpos <= hpos + 9'd1;
  end

  assign sol = (hpos == htotal);  // last slot of the line

  // memory refresh owns three fixed slots
  assign refresh = (hpos == REFRESH_SLOTS[0]) ||
                   (hpos == REFRESH_SLOTS[1]) ||
                   (hpos == REFRESH_SLOTS[2]);

  // the beam never runs past the longer line, even across standard changes
  assert property (@(posedge clk) disable iff (reset) hpos <= 9'(HTOTAL_PAL));

endmodule

//--- design/blitter_dma.sv
// blitter_dma
// blitter word engine: D pointer and word counter started by BLTSIZE,
// busy flag and a one cycle finish interrupt

module blitter_dma (
  input  logic                clk,
  input  logic                reset,
  input  logic [8:0]          hpos,
  input  logic                turbo,
  input  logic                enable,
  input  agnus_pkg::cpu_reg_t reg_wr,
  output logic                req,
  input  logic                ack,
  output logic                busy,
  output logic                int3,
  output agnus_pkg::dma_bus_t bus
);
  import agnus_pkg::*;

  chip_addr_t  ptr;
  logic [10:0] words;    // words still to go, up to 1024
  logic        size_wr;  // BLTSIZE write starts a blit
  logic        slot_ok;

  assign size_wr = reg_wr.wr && reg_wr.addr == REG_BLTSIZE;
  assign slot_ok = turbo || hpos[1:0] == 2'd1 || hpos[1:0] == 2'd2;
  assign req     = busy && enable && slot_ok;

  always_ff @(posedge clk) begin
    if (reset) begin
      ptr   <= '0;
      words <= '0;
      busy  <= 1'b0;
      int3  <= 1'b0;
    end else begin
      int3 <= 1'b0;  // single cycle pulse

      if (reg_wr.wr && reg_wr.addr == REG_BLTPTH)
        ptr[20:16] <= reg_wr.data[4:0];
      else if (reg_wr.wr && reg_wr.addr == REG_BLTPTL)
        ptr[15:1] <= reg_wr.data[15:1];
      else if (ack)
        ptr <= ptr + 1'b1;

      if (size_wr) begin
        // zero size field means 1024 words
        words <= (reg_wr.data[9:0] == '0) ? 11'd1024 : {1'b0, reg_wr.data[9:0]};
        busy  <= 1'b1;
      end else if (ack) begin
        words <= words - 11'd1;
        if (words == 11'd1) begin  // last word done
          busy <= 1'b0;
          int3 <= 1'b1;
        end
      end
    end
  end

  assign bus = '{addr: ptr, reg_addr: REG_BLTDDAT, write: 1'b1};

  // the arbiter only acks a request, and requests need busy
  assert property (@(posedge clk) disable iff (reset) ack |-> busy);

endmodule

//--- design/chip_bus_arbiter.sv
// chip_bus_arbiter
// fixed priority owner of each chip bus slot with same cycle acks,
// cpu fallback and the blitter slowdown counter

module chip_bus_arbiter (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [8:0]            hpos,
  input  logic                  turbo,
  input  logic                  bls,
  input  logic                  bltpri,
  input  agnus_pkg::cpu_reg_t   cpu,
  input  logic                  dsk_dma,
  input  logic                  aud_dma,
  input  logic                  ref_dma,
  input  logic                  spr_req,
  input  logic                  cop_req,
  input  logic                  blt_req,
  input  agnus_pkg::dma_bus_t   dsk_bus,
  input  agnus_pkg::dma_bus_t   aud_bus,
  input  agnus_pkg::dma_bus_t   spr_bus,
  input  agnus_pkg::dma_bus_t   cop_bus,
  input  agnus_pkg::dma_bus_t   blt_bus,
  output logic                  spr_ack,
  output logic                  cop_ack,
  output logic                  blt_ack,
  output agnus_pkg::cpu_reg_t   reg_wr,
  output agnus_pkg::chip_addr_t address_out,
  output agnus_pkg::reg_addr_t  reg_address_out,
  output logic                  dbr,
  output logic                  dbwe,
  output logic                  cpu_custom
);
  import agnus_pkg::*;

  logic [1:0] bls_cnt;  // cycles the cpu missed the bus
  logic       blt_ok;   // blitter not held off by slowdown
  dma_bus_t   sel;      // bus of the slot owner

  assign blt_ok = blt_req && (bls_cnt != BLS_CNT_MAX);

  // ----------------------------------------------------------
  // priority walk, first hit owns the slot
  always_comb begin
    sel     = '{addr: '0, reg_addr: REG_NONE, write: 1'b0};
    spr_ack = 1'b0;
    cop_ack = 1'b0;
    blt_ack = 1'b0;
    dbr     = 1'b1;
    if (dsk_dma)
      sel = dsk_bus;
    else if (ref_dma) begin
      // refresh holds the bus with an idle register address
    end else if (aud_dma)
      sel = aud_bus;
    else if (spr_req) begin
      sel     = spr_bus;
      spr_ack = 1'b1;
    end else if (cop_req) begin
      sel     = cop_bus;
      cop_ack = 1'b1;
    end else if (blt_ok) begin
      sel     = blt_bus;
      blt_ack = 1'b1;
    end else
      dbr = 1'b0;  // free slot goes to the cpu
  end

  assign cpu_custom      = ~dbr;
  assign address_out     = sel.addr;
  assign dbwe            = sel.write;
  assign reg_address_out = dbr ? sel.reg_addr : cpu.addr;

  // register broadcast to the engines, valid in cpu cycles only
  assign reg_wr = '{addr: cpu_custom ? cpu.addr : REG_NONE,
                    data: cpu.data,
                    wr:   cpu.wr & cpu_custom};

  // ----------------------------------------------------------
  // blitter slowdown, ticks on even slots or every slot in turbo
  always_ff @(posedge clk) begin
    if (reset)
      bls_cnt <= '0;
    else if (!hpos[0] || turbo) begin
      if (!bls || bltpri)
        bls_cnt <= '0;
      else if (bls_cnt != BLS_CNT_MAX)
        bls_cnt <= bls_cnt + 2'd1;
    end
  end

  assert property (@(posedge clk) disable iff (reset)
    $onehot0({spr_ack, cop_ack, blt_ack}));

endmodule

//--- design/dma_control.sv
// dma_control
// DMACON set/clear register, channel enables and DMACONR readback

module dma_control (
  input  logic                clk,
  input  logic                reset,
  input  agnus_pkg::cpu_reg_t reg_wr,
  input  logic                blit_busy,
  output logic                spren,
  output logic                copen,
  output logic                blten,
  output logic                bltpri,
  output logic [15:0]         dmaconr
);
  import agnus_pkg::*;

  logic [12:0] dmacon;

  always_ff @(posedge clk) begin
    if (reset)
      dmacon <= '0;
    else if (reg_wr.wr && reg_wr.addr == REG_DMACON) begin
      if (reg_wr.data[15])  // set/clr bit
        dmacon <= dmacon | reg_wr.data[12:0];
      else
        dmacon <= dmacon & ~reg_wr.data[12:0];
    end
  end

  // enables are qualified by the master bit 9
  assign spren  = dmacon[5] & dmacon[9];
  assign blten  = dmacon[6] & dmacon[9];
  assign copen  = dmacon[7] & dmacon[9];
  assign bltpri = dmacon[10];  // blitter nasty

  // readback only while the cpu owns the bus and addresses DMACONR
  always_comb begin
    if (reg_wr.addr == REG_DMACONR)
      dmaconr = {1'b0, blit_busy, 1'b0, dmacon};
    else
      dmaconr = '0;
  end

endmodule

//--- design/fixed_slot_dma.sv
// fixed_slot_dma
// pointer channels that own fixed odd beam slots, no handshake
// a slot belongs to the channel whenever its dmal line is high
// used for disk (one channel, three slots) and audio (four channels)

module fixed_slot_dma #(
  parameter int NUM_CH       = 1,
  parameter int NUM_SLOTS    = NUM_CH,  // slots per line, dealt round robin
  parameter int SLOT_BASE    = 7,
  parameter int PT_REG_BASE  = 8'h10,
  parameter int PT_STRIDE    = 8,
  parameter int DAT_REG_BASE = 8'h13,
  parameter int DAT_STRIDE   = 8
) (
  input  logic                clk,
  input  logic                reset,
  input  logic [8:0]          hpos,
  input  logic [NUM_CH-1:0]   dmal,
  input  logic                dir_write,
  input  agnus_pkg::cpu_reg_t reg_wr,
  output logic                dma,
  output agnus_pkg::dma_bus_t bus
);
  import agnus_pkg::*;

  localparam int CW = (NUM_CH > 1) ? $clog2(NUM_CH) : 1;

  chip_addr_t        ptr [NUM_CH];
  logic [NUM_CH-1:0] own;       // channel n uses this slot
  logic              in_slot;
  logic [CW-1:0]     ch;        // channel the current slot belongs to
  int                slot_off;

  // ----------------------------------------------------------
  // slot decode
  always_comb begin
    slot_off = int'(hpos) - SLOT_BASE;
    in_slot  = (slot_off >= 0) && (slot_off % SLOT_STEP == 0) &&
               (slot_off < SLOT_STEP * NUM_SLOTS);
    ch       = CW'((slot_off / SLOT_STEP) % NUM_CH);
    for (int n = 0; n < NUM_CH; n++)
      own[n] = in_slot && (int'(ch) == n) && dmal[n];
  end

  assign dma = |own;

  // ----------------------------------------------------------
  // pointers, PTH/PTL loads and post increment
  always_ff @(posedge clk) begin
    for (int n = 0; n < NUM_CH; n++) begin
      if (reset)
        ptr[n] <= '0;
      else if (reg_wr.wr && reg_wr.addr == reg_addr_t'(PT_REG_BASE + n * PT_STRIDE))
        ptr[n][20:16] <= reg_wr.data[4:0];
      else if (reg_wr.wr && reg_wr.addr == reg_addr_t'(PT_REG_BASE + n * PT_STRIDE + 1))
        ptr[n][15:1] <= reg_wr.data[15:1];
      else if (own[n])
        ptr[n] <= ptr[n] + 1'b1;  // next word seen one slot later
    end
  end

  assign bus.addr     = ptr[ch];
  assign bus.reg_addr = reg_addr_t'(DAT_REG_BASE + int'(ch) * DAT_STRIDE);
  assign bus.write    = dir_write;  // disk writes chip ram, audio only reads

  // never two channels in one slot
  assert property (@(posedge clk) disable iff (reset) $onehot0(own));

endmodule

//--- design/pointer_dma.sv
// pointer_dma
// request/ack pointer channel fetching in one slot phase inside an hpos window
// reloads from a latched pointer at start of line or on a jump strobe

module pointer_dma #(
  parameter int                   SLOT_PHASE    = 3,
  parameter int                   WIN_START     = 21,
  parameter int                   WIN_END       = 51,
  parameter agnus_pkg::reg_addr_t PT_REG        = 8'h90,
  parameter agnus_pkg::reg_addr_t DAT_REG       = 8'hA2,
  parameter bit                   RELOAD_AT_SOL = 1'b1
) (
  input  logic                clk,
  input  logic                reset,
  input  logic [8:0]          hpos,
  input  logic                sol,
  input  logic                enable,
  input  agnus_pkg::cpu_reg_t reg_wr,
  output logic                req,
  input  logic                ack,
  output agnus_pkg::dma_bus_t bus
);
  import agnus_pkg::*;

  chip_addr_t pt_latch;  // cpu written start pointer
  chip_addr_t ptr;       // live fetch pointer
  logic       in_win;
  logic       reload;

  assign in_win = (int'(hpos) >= WIN_START) && (int'(hpos) <= WIN_END);
  assign req    = enable && in_win && (hpos[1:0] == 2'(SLOT_PHASE));
  assign reload = RELOAD_AT_SOL ? sol : (reg_wr.wr && reg_wr.addr == REG_COPJMP);

  always_ff @(posedge clk) begin
    if (reset) begin
      pt_latch <= '0;
      ptr      <= '0;
    end else begin
      if (reg_wr.wr && reg_wr.addr == PT_REG)
        pt_latch[20:16] <= reg_wr.data[4:0];
      else if (reg_wr.wr && reg_wr.addr == PT_REG + 8'd1)
        pt_latch[15:1] <= reg_wr.data[15:1];
      if (reload)
        ptr <= pt_latch;
      else if (ack)
        ptr <= ptr + 1'b1;  // advance at the end of the acked slot
    end
  end

  assign bus = '{addr: ptr, reg_addr: DAT_REG, write: 1'b0};

endmodule

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, and judge the run by the log
rm -f sim.log &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_agnus_dma -f src.f \
  -o tb_agnus_dma &&
./obj_dir/tb_agnus_dma > sim.log 2>&1
cat sim.log
grep -q "Verification passed" sim.log && echo "simulation ok" || { echo "simulation bad"; exit 1; }

//--- src.f
+incdir+tests
design/agnus_pkg.sv
design/beam_slot_timer.sv
design/dma_control.sv
design/fixed_slot_dma.sv
design/pointer_dma.sv
design/blitter_dma.sv
design/chip_bus_arbiter.sv
design/agnus_dma.sv
tests/tb_agnus_dma.sv

//--- tests/dma_model.svh
// dma model
// reference model of the slot map, the dma pointers, DMACON,
// the blitter word count and the slowdown counter

`ifndef DMA_MODEL_SVH
`define DMA_MODEL_SVH

  // outputs of one bus slot, in the order they are compared
  typedef struct packed {
    logic [20:1] addr;
    logic [8:1]  reg_addr;
    logic        dbr;
    logic        dbwe;
    logic        cpu_custom;
    logic [15:0] data;
    logic        int3;
    logic        sol;
  } bus_view_t;

  typedef enum int {
    OWN_CPU,
    OWN_DISK,
    OWN_REF,
    OWN_AUD,
    OWN_SPR,
    OWN_COP,
    OWN_BLT
  } owner_e;

  logic [8:0]  m_hpos;
  logic [12:0] m_dmacon;
  chip_addr_t  m_dsk_pt;
  chip_addr_t  m_aud_pt [AUDIO_CHANNELS];
  chip_addr_t  m_spr_latch;
  chip_addr_t  m_spr_pt;
  chip_addr_t  m_cop_latch;
  chip_addr_t  m_cop_pt;
  chip_addr_t  m_blt_pt;
  logic [10:0] m_words;     // blitter words left
  logic        m_busy;
  logic        m_int3;
  logic [1:0]  m_bls_cnt;
  int          m_aud_ch;    // audio channel of this slot
  logic        m_blt_held;  // blitter wanted the slot, slowdown said no
  owner_e      m_owner;
  bus_view_t   m_exp;

  task automatic reset_model();
    m_hpos      = '0;
    m_dmacon    = '0;
    m_dsk_pt    = '0;
    m_spr_latch = '0;
    m_spr_pt    = '0;
    m_cop_latch = '0;
    m_cop_pt    = '0;
    m_blt_pt    = '0;
    m_words     = '0;
    m_busy      = 1'b0;
    m_int3      = 1'b0;
    m_bls_cnt   = '0;
    m_aud_ch    = 0;
    m_blt_held  = 1'b0;
    m_owner     = OWN_CPU;
    for (int n = 0; n < AUDIO_CHANNELS; n++)
      m_aud_pt[n] = '0;
  endtask

  // fixed slots sit every second hpos from base on
  function automatic bit in_slots(int base, int count);
    int off;
    off = int'(m_hpos) - base;
    return off >= 0 && off < 2 * count && off % 2 == 0;
  endfunction

  // PTH loads the top bits, PTL the low word, otherwise a used slot steps on
  function automatic chip_addr_t next_pointer(chip_addr_t pt, logic wr, reg_addr_t pth,
                                              logic step);
    chip_addr_t r;
    r = pt;
    if (wr && address_in == pth)
      r[20:16] = data_in[4:0];
    else if (wr && address_in == pth + 8'd1)
      r[15:1] = data_in[15:1];
    else if (step)
      r = pt + 20'd1;
    return r;
  endfunction

  // ----------------------------------------------------------
  // owner and outputs of the current slot from state and inputs
  function automatic void predict_outputs();
    logic      spr_req;
    logic      cop_req;
    logic      blt_req;
    reg_addr_t cpu_addr;
    spr_req  = m_dmacon[9] && m_dmacon[5] && m_hpos[1:0] == 2'(SPR_SLOT_PHASE) &&
               m_hpos >= SPR_WIN_START && m_hpos <= SPR_WIN_END;
    cop_req  = m_dmacon[9] && m_dmacon[7] && m_hpos[1:0] == 2'(COP_SLOT_PHASE);  // whole line
    blt_req  = m_busy && m_dmacon[9] && m_dmacon[6] &&
               (turbo || m_hpos[1:0] == 2'd1 || m_hpos[1:0] == 2'd2);
    cpu_addr = (aen && (rd || hwr || lwr)) ? address_in : REG_NONE;
    m_aud_ch = in_slots(AUDIO_SLOT_BASE, AUDIO_CHANNELS) ? (int'(m_hpos) - AUDIO_SLOT_BASE) / 2 : 0;

    if (disk_dmal && in_slots(DISK_SLOT_BASE, DISK_SLOTS))
      m_owner = OWN_DISK;
    else if (in_slots(1, 3))  // refresh at 1, 3, 5
      m_owner = OWN_REF;
    else if (in_slots(AUDIO_SLOT_BASE, AUDIO_CHANNELS) && audio_dmal[m_aud_ch])
      m_owner = OWN_AUD;
    else if (spr_req)
      m_owner = OWN_SPR;
    else if (cop_req)
      m_owner = OWN_COP;
    else if (blt_req && m_bls_cnt != BLS_CNT_MAX)
      m_owner = OWN_BLT;
    else
      m_owner = OWN_CPU;
    m_blt_held = blt_req && m_bls_cnt == BLS_CNT_MAX && m_owner == OWN_CPU;

    m_exp          = '0;
    m_exp.reg_addr = REG_NONE;  // refresh and idle
    case (m_owner)
      OWN_DISK: begin
        m_exp.addr     = m_dsk_pt;
        m_exp.reg_addr = REG_DSKDAT;
        m_exp.dbwe     = disk_write;
      end
      OWN_AUD: begin
        m_exp.addr     = m_aud_pt[m_aud_ch];
        m_exp.reg_addr = 8'(REG_AUD0DAT + AUD_STRIDE * m_aud_ch);
      end
      OWN_SPR: begin
        m_exp.addr     = m_spr_pt;
        m_exp.reg_addr = REG_SPRDAT;
      end
      OWN_COP: begin
        m_exp.addr     = m_cop_pt;
        m_exp.reg_addr = REG_COPINS;
      end
      OWN_BLT: begin
        m_exp.addr     = m_blt_pt;
        m_exp.reg_addr = REG_BLTDDAT;
        m_exp.dbwe     = 1'b1;  // blitter D channel writes
      end
      OWN_CPU: m_exp.reg_addr = cpu_addr;
      default: ;
    endcase
    m_exp.dbr        = m_owner != OWN_CPU;
    m_exp.cpu_custom = m_owner == OWN_CPU;
    if (m_owner == OWN_CPU && cpu_addr == REG_DMACONR)
      m_exp.data = {1'b0, m_busy, 1'b0, m_dmacon};
    m_exp.int3 = m_int3;
    m_exp.sol  = m_hpos == (ntsc ? 9'(HTOTAL_NTSC) : 9'(HTOTAL_PAL));
  endfunction

  // ----------------------------------------------------------
  // state at the end of the slot, all from the values seen in it
  function automatic void advance_model();
    logic       wr;
    logic [8:0] htotal;
    wr     = aen && (hwr || lwr) && m_owner == OWN_CPU;
    htotal = ntsc ? 9'(HTOTAL_NTSC) : 9'(HTOTAL_PAL);

    if (!m_hpos[0] || turbo) begin
      if (!bls || m_dmacon[10])
        m_bls_cnt = '0;
      else if (m_bls_cnt != BLS_CNT_MAX)
        m_bls_cnt = m_bls_cnt + 2'd1;
    end

    m_dsk_pt = next_pointer(m_dsk_pt, wr, REG_DSKPTH, m_owner == OWN_DISK);
    for (int n = 0; n < AUDIO_CHANNELS; n++)
      m_aud_pt[n] = next_pointer(m_aud_pt[n], wr, 8'(REG_AUD0LCH + AUD_STRIDE * n),
                                 m_owner == OWN_AUD && m_aud_ch == n);
    m_blt_pt = next_pointer(m_blt_pt, wr, REG_BLTPTH, m_owner == OWN_BLT);

    if (m_hpos == htotal)  // sprite restarts every line
      m_spr_pt = m_spr_latch;
    else if (m_owner == OWN_SPR)
      m_spr_pt = m_spr_pt + 20'd1;
    if (wr && address_in == REG_COPJMP)
      m_cop_pt = m_cop_latch;
    else if (m_owner == OWN_COP)
      m_cop_pt = m_cop_pt + 20'd1;
    m_spr_latch = next_pointer(m_spr_latch, wr, REG_SPRPTH, 1'b0);
    m_cop_latch = next_pointer(m_cop_latch, wr, REG_COP1LCH, 1'b0);

    m_int3 = 1'b0;
    if (wr && address_in == REG_BLTSIZE) begin
      m_words = (data_in[9:0] == 10'd0) ? 11'd1024 : {1'b0, data_in[9:0]};
      m_busy  = 1'b1;
    end else if (m_owner == OWN_BLT) begin
      m_words = m_words - 11'd1;
      if (m_words == 11'd0) begin
        m_busy = 1'b0;
        m_int3 = 1'b1;
      end
    end

    if (wr && address_in == REG_DMACON) begin
      if (data_in[15])
        m_dmacon = m_dmacon | data_in[12:0];
      else
        m_dmacon = m_dmacon & ~data_in[12:0];
    end
    m_hpos = (m_hpos >= htotal) ? 9'd0 : m_hpos + 9'd1;
  endfunction

`endif

//--- tests/tb_agnus_dma.sv
// tb_agnus_dma
// random cpu, disk, audio and blitter traffic on the chip bus,
// every slot compared with the reference model

module tb_agnus_dma;
  import agnus_pkg::*;

  logic        clk;
  logic        reset;
  logic        ntsc;
  logic        turbo;
  logic        bls;
  logic        aen;
  logic        rd;
  logic        hwr;
  logic        lwr;
  reg_addr_t   address_in;
  logic [15:0] data_in;
  logic        disk_dmal;
  logic        disk_write;
  logic [3:0]  audio_dmal;
  logic [15:0] data_out;
  chip_addr_t  address_out;
  reg_addr_t   reg_address_out;
  logic        dbr;
  logic        dbwe;
  logic        cpu_custom;
  logic        int3;
  logic        sol;

  int errors;       // in the running test
  int total_errors;
  int tests_run;
  int tests_failed;
  int blt_words;    // blitter slots seen on the bus
  int int3_pulses;
  int lockouts;     // slots the slowdown kept from the blitter

  `include "dma_model.svh"

  agnus_dma u_agnus_dma (.*);

  always #4 clk = ~clk;

  // ----------------------------------------------------------
  // one slot: compare once settled, step the model, on to the next falling edge
  task automatic run_cycle();
    bus_view_t got;
    logic      dut_blt;
    #1;
    predict_outputs();
    got     = {address_out, reg_address_out, dbr, dbwe, cpu_custom, data_out, int3, sol};
    dut_blt = dbr && dbwe && reg_address_out == REG_BLTDDAT;
    if (got !== m_exp) begin
      errors++;
      $display("Fail at %0t: hpos %0d owner %s addr %h/%h reg %h/%h flags %b/%b data %h/%h",
               $time, m_hpos, m_owner.name(), address_out, m_exp.addr, reg_address_out,
               m_exp.reg_addr, {dbr, dbwe, cpu_custom, int3, sol},
               {m_exp.dbr, m_exp.dbwe, m_exp.cpu_custom, m_exp.int3, m_exp.sol},
               data_out, m_exp.data);
    end
    if (dut_blt)
      blt_words++;
    if (int3)
      int3_pulses++;
    if (m_blt_held) begin
      lockouts++;
      if (dut_blt) begin
        errors++;
        $display("Fail at %0t: blitter took a slot held by the slowdown counter", $time);
      end
    end
    advance_model();
    @(negedge clk);
  endtask

  // register accesses go in hpos mod 4 = 0 slots, which the cpu owns outside turbo
  task automatic wait_cpu_slot();
    int n;
    n = 0;
    while (m_hpos[1:0] != 2'd0 && n < 8) begin
      run_cycle();
      n++;
    end
    if (m_hpos[1:0] != 2'd0) begin
      errors++;
      $display("timeout: no cpu register slot within 8 slots");
    end
  endtask

  task automatic cpu_write(reg_addr_t a, logic [15:0] d);
    turbo = 1'b0;
    wait_cpu_slot();
    aen        = 1'b1;
    hwr        = 1'($urandom);
    lwr        = !hwr;
    address_in = a;
    data_in    = d;
    run_cycle();
    aen = 1'b0;
    hwr = 1'b0;
    lwr = 1'b0;
  endtask

  task automatic cpu_read(reg_addr_t a);
    turbo = 1'b0;
    wait_cpu_slot();
    aen        = 1'b1;
    rd         = 1'b1;
    address_in = a;
    run_cycle();
    aen = 1'b0;
    rd  = 1'b0;
  endtask

  task automatic run_random(int cycles, bit contention);
    for (int i = 0; i < cycles; i++) begin
      disk_dmal  = 1'($urandom);
      disk_write = 1'($urandom);
      audio_dmal = 4'($urandom);
      if (contention) begin
        bls   = ($urandom % 4) != 0;  // cpu mostly waiting
        turbo = ($urandom % 4) == 0;
      end
      run_cycle();
    end
  endtask

  // slots up to the start of line pulse, then the pulse slot itself
  task automatic measure_line(int expected);
    int n;
    n = 0;
    while (sol !== 1'b1 && n < 400) begin
      run_cycle();
      n++;
    end
    if (sol !== 1'b1) begin
      errors++;
      $display("timeout: no start of line pulse within 400 slots");
    end else if (n != expected) begin
      errors++;
      $display("Fail at %0t: line ended after %0d slots, expected %0d", $time, n, expected);
    end
    run_cycle();
  endtask

  task automatic report_test(string name);
    tests_run++;
    total_errors += errors;
    if (errors != 0)
      tests_failed++;
    $display("test %0d %s: %0d errors", tests_run, name, errors);
    errors = 0;
  endtask

  // ----------------------------------------------------------
  initial begin
    int n;
    int size;
    void'($urandom(32'h53b7_c4ee));
    clk          = 1'b0;
    reset        = 1'b1;
    ntsc         = 1'b0;
    turbo        = 1'b0;
    bls          = 1'b0;
    aen          = 1'b0;
    rd           = 1'b0;
    hwr          = 1'b0;
    lwr          = 1'b0;
    address_in   = REG_NONE;
    data_in      = '0;
    disk_dmal    = 1'b0;
    disk_write   = 1'b0;
    audio_dmal   = '0;
    errors       = 0;
    total_errors = 0;
    tests_run    = 0;
    tests_failed = 0;
    blt_words    = 0;
    int3_pulses  = 0;
    lockouts     = 0;
    reset_model();
    repeat (4) @(negedge clk);
    reset = 1'b0;

    // idle bus, pal line then ntsc line
    measure_line(HTOTAL_PAL);
    ntsc = 1'b1;
    measure_line(HTOTAL_NTSC);
    ntsc = 1'b0;
    report_test("line timing and refresh");

    cpu_write(REG_DSKPTH, 16'($urandom));
    cpu_write(REG_DSKPTL, 16'($urandom));
    for (int ch = 0; ch < AUDIO_CHANNELS; ch++) begin
      cpu_write(8'(REG_AUD0LCH + AUD_STRIDE * ch), 16'($urandom));
      cpu_write(8'(REG_AUD0LCL + AUD_STRIDE * ch), 16'($urandom));
    end
    run_random(3 * 228, 1'b0);
    report_test("disk and audio slots");

    cpu_write(REG_SPRPTH, 16'($urandom));
    cpu_write(REG_SPRPTL, 16'($urandom));
    cpu_write(REG_COP1LCH, 16'($urandom));
    cpu_write(REG_COP1LCL, 16'($urandom));
    cpu_write(REG_COPJMP, 16'h0000);
    cpu_write(REG_DMACON, 16'h82A0);  // master, sprite, copper
    for (int i = 0; i < 12; i++) begin
      cpu_write(REG_DMACON, 16'($urandom));
      cpu_read(REG_DMACONR);
      if ($urandom % 3 == 0)
        cpu_write(REG_COPJMP, 16'h0000);
      run_random(int'($urandom % 80), 1'b0);
    end
    cpu_write(REG_DMACON, 16'h82A0);
    run_random(2 * 228, 1'b0);  // crosses sol, sprite reloads
    cpu_write(REG_COPJMP, 16'h0000);
    run_random(100, 1'b0);
    report_test("dmacon, sprite and copper");

    disk_dmal  = 1'b0;
    audio_dmal = '0;
    bls        = 1'b0;
    cpu_write(REG_DMACON, 16'h8240);  // blitter on, nasty off
    for (int b = 0; b < 3; b++) begin
      size = 1 + int'($urandom % 60);
      cpu_write(REG_BLTPTH, 16'($urandom));
      cpu_write(REG_BLTPTL, 16'($urandom));
      blt_words   = 0;
      int3_pulses = 0;
      cpu_write(REG_BLTSIZE, 16'(size));
      cpu_read(REG_DMACONR);  // busy in the readback
      n = 0;
      while (int3_pulses == 0 && n < 4000) begin
        run_cycle();
        n++;
      end
      if (int3_pulses == 0) begin
        errors++;
        $display("timeout: blit of %0d words never raised int3", size);
      end
      repeat (20) run_cycle();
      if (blt_words != size || int3_pulses != 1) begin
        errors++;
        $display("Fail at %0t: blit of %0d words ran %0d words with %0d int3 pulses",
                 $time, size, blt_words, int3_pulses);
      end
    end
    report_test("blitter word count");

    cpu_write(REG_DMACON, 16'h8640);  // nasty on, no slowdown
    cpu_write(REG_BLTSIZE, 16'h0000);  // 1024 words
    run_random(600, 1'b1);
    cpu_write(REG_DMACON, 16'h0400);
    cpu_write(REG_BLTSIZE, 16'h0000);
    lockouts = 0;
    run_random(800, 1'b1);
    if (lockouts == 0) begin
      errors++;
      $display("blitter slowdown never held the blitter off the bus");
    end
    report_test("priority and blitter slowdown");

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errors);
    if (total_errors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule
